/* list.f */
src/cpu_pkg.sv
src/branch_pkg.sv
src/branch_table_if.sv
src/branch_target_table.sv
src/branch_cond_stage.sv
src/branch_resolve_stage.sv
src/branch_unit_top.sv
tb/tb_branch_unit.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the branch unit testbench with Verilator.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -j 0 \
  --top-module tb_branch_unit -f list.f -o sim_tb_branch_unit \
  && ./obj_dir/sim_tb_branch_unit > sim.log 2>&1 \
  || echo "Build or simulation run returned an error."

cat sim.log 2>/dev/null

grep -q "^SIMULATION PASSED$" sim.log 2>/dev/null \
  && echo "Result: pass" \
  || { echo "Result: fail"; exit 1; }

/* src/branch_cond_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module branch_cond_stage
  import branch_pkg::*;
(
  input  wire               clk,
  input  wire               rst,
  input  wire               in_valid,
  output logic              in_ready,
  input  wire branch_req_t  in_data,
  output logic              out_valid,
  input  wire               out_ready,
  output branch_eval_t      out_data
);

  logic cond;
  logic load;

  // Equality also satisfies JLE and JGE.
  always_comb begin
    case (in_data.jop)
      JEQ, JZ: cond = in_data.zero;
      JNE, JNZ: cond = !in_data.zero;
      JL:  cond = in_data.less;
      JLE: cond = in_data.less || in_data.zero;
      JG:  cond = in_data.greater;
      JGE: cond = in_data.greater || in_data.zero;
      J, JR: cond = 1'b1;
      default: cond = 1'b0;
    endcase
  end

  // One slot that frees when empty or when draining this cycle.
  assign in_ready = !out_valid || out_ready;
  assign load     = in_valid && in_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid <= 1'b0;
    end else if (in_ready) begin
      out_valid <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      out_data.jop         <= in_data.jop;
      out_data.pc          <= in_data.pc;
      out_data.reg_address <= in_data.reg_address;
      out_data.imm_address <= in_data.imm_address;
      out_data.predicted   <= in_data.predicted;
      out_data.cond        <= cond;
    end
  end

endmodule

`default_nettype wire

/* src/branch_pkg.sv */
`default_nettype none

package branch_pkg;

  import cpu_pkg::*;

  localparam int JUMP_BITS = 4;

  typedef enum logic [JUMP_BITS-1:0] {
    NOP = 4'd0,
    J   = 4'd1,
    JR  = 4'd2,
    JEQ = 4'd3,
    JNE = 4'd4,
    JL  = 4'd5,
    JLE = 4'd6,
    JG  = 4'd7,
    JGE = 4'd8,
    JZ  = 4'd9,
    JNZ = 4'd10
  } jop_t;

  // Direct-mapped prediction table geometry.
  localparam int TABLE_ENTRIES    = 16;
  localparam int TABLE_INDEX_BITS = 4;

  // Request from execute, flags straight off the ALU.
  typedef struct packed {
    jop_t                  jop;
    logic [ADDR_WIDTH-1:0] pc;
    logic [ADDR_WIDTH-1:0] reg_address;
    logic [ADDR_WIDTH-1:0] imm_address;
    logic                  zero;
    logic                  less;
    logic                  greater;
    logic                  predicted;
  } branch_req_t;

  // Flags are folded into cond after stage one.
  typedef struct packed {
    jop_t                  jop;
    logic [ADDR_WIDTH-1:0] pc;
    logic [ADDR_WIDTH-1:0] reg_address;
    logic [ADDR_WIDTH-1:0] imm_address;
    logic                  predicted;
    logic                  cond;
  } branch_eval_t;

endpackage

`default_nettype wire

/* src/branch_resolve_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module branch_resolve_stage
  import cpu_pkg::*;
  import branch_pkg::*;
(
  input  wire                        clk,
  input  wire                        rst,
  input  wire                        in_valid,
  output logic                       in_ready,
  input  wire branch_eval_t          in_data,
  output logic                       out_valid,
  input  wire                        out_ready,
  output logic [NUM_PIPE_MASKS-1:0]  flush,
  output logic [ADDR_WIDTH-1:0]      jump_address,
  branch_table_if.update             tbl
);

  logic [NUM_PIPE_MASKS-1:0] flush_d;
  logic [ADDR_WIDTH-1:0]     jump_d;
  logic                      load;
  logic                      mispredict;

  assign mispredict = in_data.cond ^ in_data.predicted;

  always_comb begin
    case (in_data.jop)
      NOP: flush_d = '0;
      J:   flush_d = PIPE_REG_EX_MEM;
      JR:  flush_d = FLUSH_ALL;
      JEQ, JNE, JL, JLE, JG, JGE, JZ, JNZ: begin
        if (mispredict) begin
          flush_d = FLUSH_ALL;
        end else if (in_data.cond && in_data.predicted) begin
          flush_d = PIPE_REG_EX_MEM;
        end else begin
          flush_d = '0;
        end
      end
      default: flush_d = '0;
    endcase
  end

  // Predicted taken but fell through, so fetch restarts after the branch.
  always_comb begin
    if (in_data.jop == JR) begin
      jump_d = in_data.reg_address;
    end else if (in_data.predicted && !in_data.cond) begin
      jump_d = in_data.pc + ADDR_WIDTH'(1);
    end else begin
      jump_d = in_data.imm_address;
    end
  end

  assign in_ready = !out_valid || out_ready;
  assign load     = in_valid && in_ready;

  // Table learns on the same edge the result is registered.
  assign tbl.wr_en  = load && in_data.cond && !in_data.predicted && (in_data.jop != NOP);
  assign tbl.wr_key = in_data.pc;
  assign tbl.wr_val = jump_d;

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid <= 1'b0;
    end else if (in_ready) begin
      out_valid <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      flush        <= flush_d;
      jump_address <= jump_d;
    end
  end

endmodule

`default_nettype wire

/* src/branch_table_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface branch_table_if import cpu_pkg::*; ();

  // Update side written on a taken branch that fetch missed.
  logic                  wr_en;
  logic [ADDR_WIDTH-1:0] wr_key;
  logic [ADDR_WIDTH-1:0] wr_val;

  // Lookup side with fetch pc in and prediction out in the same cycle.
  logic [ADDR_WIDTH-1:0] rd_key;
  logic [ADDR_WIDTH-1:0] rd_val;
  logic                  rd_hit;

  modport update (
    output wr_en, wr_key, wr_val
  );

  modport lookup (
    output rd_key,
    input  rd_val, rd_hit
  );

  // The table takes the update and the key and returns the prediction.
  modport storage (
    input  wr_en, wr_key, wr_val, rd_key,
    output rd_val, rd_hit
  );

endinterface

`default_nettype wire

/* src/branch_target_table.sv */
`timescale 1ns/1ps
`default_nettype none

module branch_target_table
  import cpu_pkg::*;
  import branch_pkg::*;
(
  input  wire                    clk,
  input  wire                    rst,
  branch_table_if.storage        tbl
);

  logic [TABLE_ENTRIES-1:0] entry_valid;
  logic [ADDR_WIDTH-1:0]    entry_tag    [TABLE_ENTRIES];
  logic [ADDR_WIDTH-1:0]    entry_target [TABLE_ENTRIES];

  logic [TABLE_INDEX_BITS-1:0] wr_index;
  logic [TABLE_INDEX_BITS-1:0] rd_index;

  // Low pc bits select the entry.
  assign wr_index = tbl.wr_key[TABLE_INDEX_BITS-1:0];
  assign rd_index = tbl.rd_key[TABLE_INDEX_BITS-1:0];

  always_ff @(posedge clk) begin
    if (rst) begin
      entry_valid <= '0;
    end else if (tbl.wr_en) begin
      entry_valid[wr_index] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (tbl.wr_en) begin
      entry_tag[wr_index]    <= tbl.wr_key;
      entry_target[wr_index] <= tbl.wr_val;
    end
  end

  // Full pc is kept as the tag, so aliases on the index never hit.
  assign tbl.rd_hit = entry_valid[rd_index] && (entry_tag[rd_index] == tbl.rd_key);
  assign tbl.rd_val = entry_target[rd_index];

endmodule

`default_nettype wire

/* src/branch_unit_top.sv */
`timescale 1ns/1ps
`default_nettype none

module branch_unit_top
  import cpu_pkg::*;
  import branch_pkg::*;
(
  input  wire                        clk,
  input  wire                        rst,

  input  wire                        req_valid,
  output logic                       req_ready,
  input  wire jop_t                  req_jop,
  input  wire [ADDR_WIDTH-1:0]       req_pc,
  input  wire [ADDR_WIDTH-1:0]       req_reg_address,
  input  wire [ADDR_WIDTH-1:0]       req_imm_address,
  input  wire                        req_zero,
  input  wire                        req_less,
  input  wire                        req_greater,
  input  wire                        req_predicted,

  output logic                       res_valid,
  input  wire                        res_ready,
  output logic [NUM_PIPE_MASKS-1:0]  res_flush,
  output logic [ADDR_WIDTH-1:0]      res_jump_address,

  input  wire [ADDR_WIDTH-1:0]       fetch_pc,
  output logic                       pred_taken,
  output logic [ADDR_WIDTH-1:0]      pred_target
);

  branch_req_t  req_data;
  logic         s1_valid;
  logic         s1_ready;
  branch_eval_t s1_data;

  branch_table_if tbl_if ();

  assign req_data = '{
    jop:         req_jop,
    pc:          req_pc,
    reg_address: req_reg_address,
    imm_address: req_imm_address,
    zero:        req_zero,
    less:        req_less,
    greater:     req_greater,
    predicted:   req_predicted
  };

  branch_cond_stage u_cond (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (req_valid),
    .in_ready  (req_ready),
    .in_data   (req_data),
    .out_valid (s1_valid),
    .out_ready (s1_ready),
    .out_data  (s1_data)
  );

  branch_resolve_stage u_resolve (
    .clk          (clk),
    .rst          (rst),
    .in_valid     (s1_valid),
    .in_ready     (s1_ready),
    .in_data      (s1_data),
    .out_valid    (res_valid),
    .out_ready    (res_ready),
    .flush        (res_flush),
    .jump_address (res_jump_address),
    .tbl          (tbl_if)
  );

  branch_target_table u_table (
    .clk (clk),
    .rst (rst),
    .tbl (tbl_if)
  );

  // Fetch lookup.
  assign tbl_if.rd_key = fetch_pc;
  assign pred_taken    = tbl_if.rd_hit;
  assign pred_target   = tbl_if.rd_val;

endmodule

`default_nettype wire

/* src/cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

  // Instruction address width.
  localparam int ADDR_WIDTH = 16;

  // One flush bit per pipeline register.
  localparam int NUM_PIPE_MASKS = 4;

  localparam logic [NUM_PIPE_MASKS-1:0] PIPE_REG_PC     = 4'b0001;
  localparam logic [NUM_PIPE_MASKS-1:0] PIPE_REG_IF_ID  = 4'b0010;
  localparam logic [NUM_PIPE_MASKS-1:0] PIPE_REG_ID_EX  = 4'b0100;
  localparam logic [NUM_PIPE_MASKS-1:0] PIPE_REG_EX_MEM = 4'b1000;

  // Full flush on a mispredict or a register jump.
  localparam logic [NUM_PIPE_MASKS-1:0] FLUSH_ALL = PIPE_REG_PC
                                                  | PIPE_REG_IF_ID
                                                  | PIPE_REG_ID_EX
                                                  | PIPE_REG_EX_MEM;

endpackage

`default_nettype wire

/* tb/tb_branch_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_branch_unit
  import cpu_pkg::*;
  import branch_pkg::*;
;

  localparam int TIMEOUT_CYCLES = 200;
  localparam int RANDOM_ITEMS   = 300;

  typedef struct packed {
    logic [NUM_PIPE_MASKS-1:0] flush;
    logic [ADDR_WIDTH-1:0]     jump;
    logic                      wr;
  } expect_t;

  logic clk;
  logic rst;
  logic req_valid;
  logic req_ready;
  branch_req_t req;
  logic res_valid;
  logic res_ready;
  logic [NUM_PIPE_MASKS-1:0] res_flush;
  logic [ADDR_WIDTH-1:0] res_jump_address;
  logic [ADDR_WIDTH-1:0] fetch_pc;
  logic pred_taken;
  logic [ADDR_WIDTH-1:0] pred_target;
  logic bp_on;

  branch_req_t pending [$];
  branch_req_t chk_req;
  expect_t     chk_exp;

  // Table model that follows each writing item as it leaves the DUT.
  logic                  model_valid  [TABLE_ENTRIES];
  logic [ADDR_WIDTH-1:0] model_tag    [TABLE_ENTRIES];
  logic [ADDR_WIDTH-1:0] model_target [TABLE_ENTRIES];

  int err_count = 0;
  int timeout_count = 0;
  int sent_count = 0;
  int acc_count = 0;
  int res_count = 0;
  int latency;

  branch_unit_top dut0 (
    .clk              (clk),
    .rst              (rst),
    .req_valid        (req_valid),
    .req_ready        (req_ready),
    .req_jop          (req.jop),
    .req_pc           (req.pc),
    .req_reg_address  (req.reg_address),
    .req_imm_address  (req.imm_address),
    .req_zero         (req.zero),
    .req_less         (req.less),
    .req_greater      (req.greater),
    .req_predicted    (req.predicted),
    .res_valid        (res_valid),
    .res_ready        (res_ready),
    .res_flush        (res_flush),
    .res_jump_address (res_jump_address),
    .fetch_pc         (fetch_pc),
    .pred_taken       (pred_taken),
    .pred_target      (pred_target)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic expect_t expect_result(branch_req_t r);
    expect_t e;
    logic taken;
    taken = 1'b0;
    case (r.jop)
      J, JR:    taken = 1'b1;
      JEQ, JZ:  taken = r.zero;
      JNE, JNZ: taken = !r.zero;
      JL:       taken = r.less;
      JLE:      taken = r.less | r.zero;
      JG:       taken = r.greater;
      JGE:      taken = r.greater | r.zero;
      default:  taken = 1'b0;
    endcase
    if (r.jop == NOP) e.flush = '0;
    else if (r.jop == J) e.flush = PIPE_REG_EX_MEM;
    else if (r.jop == JR) e.flush = FLUSH_ALL;
    else if (taken != r.predicted) e.flush = FLUSH_ALL;
    else if (taken) e.flush = PIPE_REG_EX_MEM;
    else e.flush = '0;
    if (r.jop == JR) e.jump = r.reg_address;
    else if (r.predicted && !taken) e.jump = r.pc + 16'd1;
    else e.jump = r.imm_address;
    e.wr = taken && !r.predicted && (r.jop != NOP);
    return e;
  endfunction

  function automatic branch_req_t rand_req(jop_t op, logic [2:0] flags, logic pred);
    branch_req_t r;
    r.jop         = op;
    r.pc          = ADDR_WIDTH'($urandom);
    r.reg_address = ADDR_WIDTH'($urandom);
    r.imm_address = ADDR_WIDTH'($urandom);
    r.zero        = flags[0];
    r.less        = flags[1];
    r.greater     = flags[2];
    r.predicted   = pred;
    return r;
  endfunction

  // Handshakes are sampled at the falling edge, ahead of the rising edge that takes them.
  always @(negedge clk) begin
    if (!rst && req_valid && req_ready) begin
      pending.push_back(req);
      acc_count++;
    end
    if (!rst && res_valid && res_ready) begin
      assert (pending.size() != 0) else begin
        err_count++;
        $display("ERROR: a result came out with no request outstanding");
      end
      if (pending.size() != 0) begin
        chk_req = pending.pop_front();
        chk_exp = expect_result(chk_req);
        res_count++;
        assert (res_flush == chk_exp.flush) else begin
          err_count++;
          $display("FAIL res_flush got %h expected %h (pc %h)", res_flush, chk_exp.flush,
                   chk_req.pc);
        end
        assert (res_jump_address == chk_exp.jump) else begin
          err_count++;
          $display("FAIL res_jump_address got %h expected %h (pc %h)", res_jump_address,
                   chk_exp.jump, chk_req.pc);
        end
        if (chk_exp.wr) begin
          model_valid[chk_req.pc[TABLE_INDEX_BITS-1:0]]  = 1'b1;
          model_tag[chk_req.pc[TABLE_INDEX_BITS-1:0]]    = chk_req.pc;
          model_target[chk_req.pc[TABLE_INDEX_BITS-1:0]] = chk_exp.jump;
        end
      end
    end
  end

  // Back-pressure on the result side.
  initial begin
    res_ready = 1'b1;
    forever begin
      @(posedge clk);
      #1;
      res_ready = bp_on ? ($urandom_range(99) < 60) : 1'b1;
    end
  end

  task automatic send_req(input branch_req_t r);
    int waited;
    req       = r;
    req_valid = 1'b1;
    sent_count++;
    waited = 0;
    @(negedge clk);
    while (!req_ready && waited < TIMEOUT_CYCLES) begin
      @(negedge clk);
      waited++;
    end
    if (!req_ready) begin
      timeout_count++;
      $display("ERROR: timed out waiting for the DUT to accept a request");
    end
    @(posedge clk);
    #1;
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    @(negedge clk);
    while ((pending.size() != 0 || res_valid) && waited < TIMEOUT_CYCLES) begin
      @(negedge clk);
      waited++;
    end
    if (pending.size() != 0 || res_valid) begin
      timeout_count++;
      $display("ERROR: timed out waiting for outstanding results to drain");
    end
    @(posedge clk);
    #1;
  endtask

  task automatic probe(input logic [ADDR_WIDTH-1:0] pc, input logic exp_hit,
                       input logic [ADDR_WIDTH-1:0] exp_target);
    fetch_pc = pc;
    @(negedge clk);
    assert (pred_taken == exp_hit) else begin
      err_count++;
      $display("FAIL pred_taken got %h expected %h (fetch_pc %h)", pred_taken, exp_hit, pc);
    end
    if (exp_hit) begin
      assert (pred_target == exp_target) else begin
        err_count++;
        $display("FAIL pred_target got %h expected %h (fetch_pc %h)", pred_target,
                 exp_target, pc);
      end
    end
    @(posedge clk);
    #1;
  endtask

  initial begin
    branch_req_t r;
    void'($urandom(32'h4d2a_3324));
    rst = 1'b1;
    req_valid = 1'b0;
    req = '0;
    fetch_pc = '0;
    bp_on = 1'b0;
    for (int i = 0; i < TABLE_ENTRIES; i++) begin
      model_valid[i]  = 1'b0;
      model_tag[i]    = '0;
      model_target[i] = '0;
    end
    repeat (5) @(posedge clk);
    #1;
    rst = 1'b0;

    // State right after reset.
    @(negedge clk);
    assert (res_valid == 1'b0) else begin
      err_count++;
      $display("FAIL res_valid got %h expected %h", res_valid, 1'b0);
    end
    assert (req_ready == 1'b1) else begin
      err_count++;
      $display("FAIL req_ready got %h expected %h", req_ready, 1'b1);
    end
    @(posedge clk);
    #1;
    for (int i = 0; i < 2 * TABLE_ENTRIES; i++) probe(ADDR_WIDTH'(i * 37), 1'b0, '0);

    // Index aliasing followed by a not-taken and a correctly predicted branch.
    r = rand_req(JEQ, 3'b001, 1'b0);
    r.pc = 16'h1234;
    r.imm_address = 16'h0100;
    send_req(r);
    r.pc = 16'h5634;
    r.imm_address = 16'h0200;
    send_req(r);
    send_req('{jop: JNE, pc: 16'h7777, reg_address: 16'h0, imm_address: 16'h0300,
               zero: 1'b1, less: 1'b0, greater: 1'b0, predicted: 1'b0});
    send_req('{jop: JG, pc: 16'h7787, reg_address: 16'h0, imm_address: 16'h0400,
               zero: 1'b0, less: 1'b0, greater: 1'b1, predicted: 1'b1});
    req_valid = 1'b0;
    wait_drain();
    probe(16'h1234, 1'b0, '0);
    probe(16'h5634, 1'b1, 16'h0200);
    probe(16'h7777, 1'b0, '0);
    probe(16'h7787, 1'b0, '0);

    // Request to result latency in clock edges with the handshake edge counted.
    req = rand_req(JG, 3'b100, 1'b1);
    req_valid = 1'b1;
    sent_count++;
    @(posedge clk);
    #1;
    req_valid = 1'b0;
    latency = 1;
    while (latency < TIMEOUT_CYCLES) begin
      @(negedge clk);
      if (res_valid) break;
      @(posedge clk);
      #1;
      latency++;
    end
    if (latency >= TIMEOUT_CYCLES) begin
      timeout_count++;
      $display("ERROR: timed out waiting for res_valid after a single request");
    end
    assert (latency == 2) else begin
      err_count++;
      $display("FAIL res_valid latency got %h expected %h", latency, 2);
    end
    @(posedge clk);
    #1;
    wait_drain();

    // Every operation against every flag pattern and both predictions.
    for (int op = 0; op <= 10; op++) begin
      for (int f = 0; f < 8; f++) begin
        for (int p = 0; p < 2; p++) begin
          send_req(rand_req(jop_t'(op[3:0]), f[2:0], p[0]));
        end
      end
    end
    req_valid = 1'b0;
    wait_drain();

    bp_on = 1'b1;
    for (int n = 0; n < RANDOM_ITEMS; n++) begin
      if ($urandom_range(3) == 0) begin
        req_valid = 1'b0;
        @(posedge clk);
        #1;
      end
      send_req(rand_req(jop_t'(4'($urandom_range(10))), 3'($urandom), 1'($urandom)));
    end
    req_valid = 1'b0;
    wait_drain();
    bp_on = 1'b0;

    // Table contents against the model.
    for (int i = 0; i < TABLE_ENTRIES; i++) begin
      if (model_valid[i]) begin
        probe(model_tag[i], 1'b1, model_target[i]);
        probe(model_tag[i] ^ 16'h0100, 1'b0, '0);
      end else begin
        probe({12'ha5c, 4'(i)}, 1'b0, '0);
      end
    end

    assert (acc_count == sent_count && res_count == acc_count) else begin
      err_count++;
      $display("ERROR: item counts disagree, %0d sent, %0d accepted, %0d results",
               sent_count, acc_count, res_count);
    end

    $display("Errors: %0d, timeouts: %0d, results checked: %0d", err_count, timeout_count,
             res_count);
    if (err_count == 0 && timeout_count == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
